// ==== list.f ====
hw/ext_mem_pkg.sv
hw/wt_cache.sv
hw/be_merge.sv
hw/ext_mem.sv
testbench/tb_mem_model.sv
testbench/tb_ext_mem.sv

// ==== Makefile ====
# Verilator build of the ext_mem testbench

VERILATOR   ?= verilator
TOP         ?= tb_ext_mem
FILELIST    ?= list.f
BUILD_DIR   ?= obj_dir
JOBS        ?= 0
VFLAGS      ?= --binary --timing --assert --timescale 1ns/1ps
EXTRA_FLAGS ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv) $(wildcard testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) -j $(JOBS) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_ext_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ext_mem;

   localparam int MEM_WORDS      = 1 << ext_mem_pkg::ADDR_W;
   localparam int N_OPS          = 100;    // Random accesses per port
   localparam int TIMEOUT_CYCLES = 20000;  // About 250 accesses at up to 80 cycles each

   logic clk;
   logic arst;

   logic                         i_req;
   ext_mem_pkg::waddr_t          i_addr;
   ext_mem_pkg::word_t           i_wdata;
   ext_mem_pkg::wstrb_t          i_wstrb;
   ext_mem_pkg::word_t           i_rdata;
   logic                         i_ack;
   logic                         i_rvalid;

   logic                         d_req;
   logic [ext_mem_pkg::ADDR_W:0] d_addr;  // Top bit is the control region
   ext_mem_pkg::word_t           d_wdata;
   ext_mem_pkg::wstrb_t          d_wstrb;
   ext_mem_pkg::word_t           d_rdata;
   logic                         d_ack;
   logic                         d_rvalid;

   logic                         mem_req;
   ext_mem_pkg::waddr_t          mem_addr;
   ext_mem_pkg::word_t           mem_wdata;
   ext_mem_pkg::wstrb_t          mem_wstrb;
   ext_mem_pkg::word_t           mem_rdata;
   logic                         mem_ack;

   ext_mem_pkg::word_t shadow [MEM_WORDS];  // Expected memory contents
   ext_mem_pkg::word_t rnd_i [N_OPS];       // Op, address and data per access
   ext_mem_pkg::word_t rnd_d [N_OPS];
   integer             seed = 32'h28ca;
   int                 cycle_cnt = 0;

   ext_mem dut (
      .clk_i(clk), .arst_i(arst),
      .i_req_i(i_req), .i_addr_i(i_addr), .i_wdata_i(i_wdata), .i_wstrb_i(i_wstrb),
      .i_rdata_o(i_rdata), .i_ack_o(i_ack), .i_rvalid_o(i_rvalid),
      .d_req_i(d_req), .d_addr_i(d_addr), .d_wdata_i(d_wdata), .d_wstrb_i(d_wstrb),
      .d_rdata_o(d_rdata), .d_ack_o(d_ack), .d_rvalid_o(d_rvalid),
      .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
      .mem_wstrb_o(mem_wstrb), .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack)
   );

   tb_mem_model mem_model (
      .clk_i(clk), .arst_i(arst),
      .req_i(mem_req), .addr_i(mem_addr), .wdata_i(mem_wdata), .wstrb_i(mem_wstrb),
      .rdata_o(mem_rdata), .ack_o(mem_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input ext_mem_pkg::word_t got,
                             input ext_mem_pkg::word_t exp);
      if (got !== exp) begin
         $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
         abort_run();
      end
   endtask

   // Preload value, every address bit shows up twice
   function automatic ext_mem_pkg::word_t fill_pattern(input ext_mem_pkg::waddr_t a);
      return {2'b10, a, 2'b01, ~a};
   endfunction

   function automatic ext_mem_pkg::word_t merge_bytes(input ext_mem_pkg::word_t old,
                                                      input ext_mem_pkg::word_t wdata,
                                                      input ext_mem_pkg::wstrb_t strb);
      ext_mem_pkg::word_t res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
      end
      return res;
   endfunction

   // One d port transfer, lat counts cycles from first sample of req to ack
   task automatic d_access(input logic ctrl, input ext_mem_pkg::waddr_t addr,
                           input ext_mem_pkg::word_t wdata, input ext_mem_pkg::wstrb_t wstrb,
                           output ext_mem_pkg::word_t rdata, output logic rvalid,
                           output int lat);
      int n;
      n = 0;
      @(posedge clk);
      d_req   <= 1'b1;
      d_addr  <= {ctrl, addr};
      d_wdata <= wdata;
      d_wstrb <= wstrb;
      do begin
         @(posedge clk);
         n++;
      end while (!d_ack);  // Pre-edge value
      rdata  = d_rdata;
      rvalid = d_rvalid;
      lat    = n - 1;
      d_req <= 1'b0;
   endtask

   task automatic i_access(input ext_mem_pkg::waddr_t addr, input ext_mem_pkg::word_t wdata,
                           input ext_mem_pkg::wstrb_t wstrb, output ext_mem_pkg::word_t rdata,
                           output logic rvalid, output int lat);
      int n;
      n = 0;
      @(posedge clk);
      i_req   <= 1'b1;
      i_addr  <= addr;
      i_wdata <= wdata;
      i_wstrb <= wstrb;
      do begin
         @(posedge clk);
         n++;
      end while (!i_ack);
      rdata  = i_rdata;
      rvalid = i_rvalid;
      lat    = n - 1;
      i_req <= 1'b0;
   endtask

   task automatic d_write(input ext_mem_pkg::waddr_t addr, input ext_mem_pkg::word_t wdata,
                          input ext_mem_pkg::wstrb_t wstrb);
      ext_mem_pkg::word_t rdata;
      logic               rvalid;
      int                 lat;
      d_access(1'b0, addr, wdata, wstrb, rdata, rvalid, lat);
      check_bit("d_rvalid_o", rvalid, 1'b0);
      shadow[addr] = merge_bytes(shadow[addr], wdata, wstrb);
      check_word("mem_wdata_o", mem_model.mem[addr], shadow[addr]);  // Write reached memory
   endtask

   task automatic d_read(input ext_mem_pkg::waddr_t addr, output int lat);
      ext_mem_pkg::word_t rdata;
      logic               rvalid;
      d_access(1'b0, addr, '0, '0, rdata, rvalid, lat);
      check_bit("d_rvalid_o", rvalid, 1'b1);
      check_word("d_rdata_o", rdata, shadow[addr]);
   endtask

   task automatic i_write(input ext_mem_pkg::waddr_t addr, input ext_mem_pkg::word_t wdata,
                          input ext_mem_pkg::wstrb_t wstrb);
      ext_mem_pkg::word_t rdata;
      logic               rvalid;
      int                 lat;
      i_access(addr, wdata, wstrb, rdata, rvalid, lat);
      check_bit("i_rvalid_o", rvalid, 1'b0);
      shadow[addr] = merge_bytes(shadow[addr], wdata, wstrb);
      check_word("mem_wdata_o", mem_model.mem[addr], shadow[addr]);  // Write reached memory
   endtask

   task automatic i_read(input ext_mem_pkg::waddr_t addr, output int lat);
      ext_mem_pkg::word_t rdata;
      logic               rvalid;
      i_access(addr, '0, '0, rdata, rvalid, lat);
      check_bit("i_rvalid_o", rvalid, 1'b1);
      check_word("i_rdata_o", rdata, shadow[addr]);
   endtask

   // Invalidates all three caches
   task automatic ctrl_write();
      ext_mem_pkg::word_t rdata;
      logic               rvalid;
      int                 lat;
      d_access(1'b1, '0, 32'h1, 4'hf, rdata, rvalid, lat);
      check_bit("d_rvalid_o", rvalid, 1'b0);
      check_count("control write ack latency", lat, 1);
   endtask

   task automatic test_reset_levels();
      @(posedge clk);
      check_bit("i_ack_o", i_ack, 1'b0);
      check_bit("d_ack_o", d_ack, 1'b0);
      check_bit("i_rvalid_o", i_rvalid, 1'b0);
      check_bit("d_rvalid_o", d_rvalid, 1'b0);
      check_bit("mem_req_o", mem_req, 1'b0);
   endtask

   task automatic test_write_read_hit();
      int lat;
      d_write(14'h0104, 32'ha5c3_1e7f, 4'b0101);  // Miss, no allocate
      d_read(14'h0104, lat);                      // Fills dcache and L2
      d_read(14'h0104, lat);
      check_count("d port hit latency", lat, 2);
      d_write(14'h0104, 32'h5a00_0000, 4'b1000);  // Write hit updates line
      d_read(14'h0104, lat);
      check_count("d port hit latency", lat, 2);
   endtask

   task automatic test_i_port_read();
      int lat;
      i_read(14'h0040, lat);  // Preloaded word
      i_read(14'h0043, lat);
      check_count("i port hit latency", lat, 2);
      d_write(14'h0208, 32'hdead_beef, 4'hf);  // Line icache never loaded
      i_read(14'h0208, lat);
   endtask

   // Both L1 misses meet in the merge
   task automatic test_parallel();
      int lat_i;
      int lat_d;
      fork
         i_read(14'h0300, lat_i);
         d_read(14'h0410, lat_d);
      join
      fork
         i_read(14'h0304, lat_i);
         d_write(14'h0414, 32'h0123_4567, 4'b0011);
      join
      d_read(14'h0414, lat_d);
   endtask

   task automatic test_invalidate();
      int lat;
      d_read(14'h0520, lat);
      i_read(14'h0630, lat);
      mem_model.backdoor_write(14'h0520, 32'h1111_2222);
      mem_model.backdoor_write(14'h0630, 32'h3333_4444);
      d_read(14'h0520, lat);  // Stale copy still cached
      i_read(14'h0630, lat);
      shadow[14'h0520] = 32'h1111_2222;
      shadow[14'h0630] = 32'h3333_4444;
      ctrl_write();
      d_read(14'h0520, lat);
      i_read(14'h0630, lat);
   endtask

   // i port stays in 0x0800..0x08ff so the L1 copies never overlap
   task automatic run_i_ops();
      ext_mem_pkg::waddr_t addr;
      ext_mem_pkg::wstrb_t strb;
      int                  lat;
      for (int k = 0; k < N_OPS; k++) begin
         addr = {6'h08, rnd_i[k][7:0]};
         strb = rnd_i[k][11:8];
         if (rnd_i[k][12] && strb != '0) begin
            i_write(addr, rnd_i[k], strb);
         end else begin
            i_read(addr, lat);
         end
      end
   endtask

   // d port in 0x1800..0x18ff, with an occasional invalidate
   task automatic run_d_ops();
      ext_mem_pkg::waddr_t addr;
      ext_mem_pkg::wstrb_t strb;
      int                  lat;
      for (int k = 0; k < N_OPS; k++) begin
         addr = {6'h18, rnd_d[k][7:0]};
         strb = rnd_d[k][11:8];
         if (rnd_d[k][15:13] == 3'd0) begin
            ctrl_write();
         end else if (rnd_d[k][12] && strb != '0) begin
            d_write(addr, rnd_d[k], strb);
         end else begin
            d_read(addr, lat);
         end
      end
   endtask

   task automatic test_random();
      ctrl_write();  // Drop lines left by earlier tests
      for (int k = 0; k < N_OPS; k++) begin
         rnd_i[k] = $random(seed);
         rnd_d[k] = $random(seed);
      end
      fork
         run_i_ops();
         run_d_ops();
      join
   endtask

   initial begin
      arst    = 1'b1;
      i_req   = 1'b0;
      i_addr  = '0;
      i_wdata = '0;
      i_wstrb = '0;
      d_req   = 1'b0;
      d_addr  = '0;
      d_wdata = '0;
      d_wstrb = '0;
      for (int a = 0; a < MEM_WORDS; a++) begin
         shadow[a] = fill_pattern(ext_mem_pkg::waddr_t'(a));
         mem_model.backdoor_write(ext_mem_pkg::waddr_t'(a), shadow[a]);
      end
      repeat (16) @(posedge clk);
      arst <= 1'b0;
      test_reset_levels();
      test_write_read_hit();
      test_i_port_read();
      test_parallel();
      test_invalidate();
      test_random();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
   input  wire logic                clk_i,
   input  wire logic                arst_i,
   input  wire logic                req_i,
   input  wire ext_mem_pkg::waddr_t addr_i,
   input  wire ext_mem_pkg::word_t  wdata_i,
   input  wire ext_mem_pkg::wstrb_t wstrb_i,
   output ext_mem_pkg::word_t       rdata_o,
   output logic                     ack_o
);

   ext_mem_pkg::word_t mem [1 << ext_mem_pkg::ADDR_W];

   integer seed = 32'h28ca;  // Latency draw

   logic                busy_q;
   logic [1:0]          wait_q;   // Cycles left before ack
   ext_mem_pkg::waddr_t addr_q;
   ext_mem_pkg::word_t  wdata_q;
   ext_mem_pkg::wstrb_t wstrb_q;

   // One access at a time, ack 1 to 4 cycles after accept
   always @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q  <= 1'b0;
         wait_q  <= '0;
         ack_o   <= 1'b0;
         rdata_o <= '0;
      end else begin
         ack_o <= 1'b0;
         if (busy_q) begin
            if (wait_q == 2'd0) begin
               busy_q  <= 1'b0;
               ack_o   <= 1'b1;
               rdata_o <= mem[addr_q];  // Old word, read before the write below
               for (int b = 0; b < ext_mem_pkg::STRB_W; b++) begin
                  if (wstrb_q[b]) begin
                     mem[addr_q][8*b +: 8] = wdata_q[8*b +: 8];
                  end
               end
            end else begin
               wait_q <= wait_q - 2'd1;
            end
         end else if (req_i && !ack_o) begin  // Next request one cycle after ack
            busy_q  <= 1'b1;
            wait_q  <= 2'($random(seed));
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
         end
      end
   end

   // Direct array access, bypasses the port
   task automatic backdoor_write(input ext_mem_pkg::waddr_t addr, input ext_mem_pkg::word_t data);
      mem[addr] = data;
   endtask

endmodule

`default_nettype wire

// ==== hw/ext_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_mem (
   input  wire logic                        clk_i,
   input  wire logic                        arst_i,
   // Instruction port
   input  wire logic                        i_req_i,
   input  wire ext_mem_pkg::waddr_t         i_addr_i,
   input  wire ext_mem_pkg::word_t          i_wdata_i,
   input  wire ext_mem_pkg::wstrb_t         i_wstrb_i,
   output ext_mem_pkg::word_t               i_rdata_o,
   output logic                             i_ack_o,
   output logic                             i_rvalid_o,
   // Data port, top bit picks the control region
   input  wire logic                        d_req_i,
   input  wire logic [ext_mem_pkg::ADDR_W:0] d_addr_i,
   input  wire ext_mem_pkg::word_t          d_wdata_i,
   input  wire ext_mem_pkg::wstrb_t         d_wstrb_i,
   output ext_mem_pkg::word_t               d_rdata_o,
   output logic                             d_ack_o,
   output logic                             d_rvalid_o,
   // Off-chip word port
   output logic                             mem_req_o,
   output ext_mem_pkg::waddr_t              mem_addr_o,
   output ext_mem_pkg::word_t               mem_wdata_o,
   output ext_mem_pkg::wstrb_t              mem_wstrb_o,
   input  wire ext_mem_pkg::word_t          mem_rdata_i,
   input  wire logic                        mem_ack_i
);

   // icache back-end
   logic                ic_be_req;
   ext_mem_pkg::waddr_t ic_be_addr;
   ext_mem_pkg::word_t  ic_be_wdata;
   ext_mem_pkg::wstrb_t ic_be_wstrb;
   ext_mem_pkg::word_t  ic_be_rdata;
   logic                ic_be_ack;

   // dcache back-end
   logic                dc_be_req;
   ext_mem_pkg::waddr_t dc_be_addr;
   ext_mem_pkg::word_t  dc_be_wdata;
   ext_mem_pkg::wstrb_t dc_be_wstrb;
   ext_mem_pkg::word_t  dc_be_rdata;
   logic                dc_be_ack;

   // Merged front-end of L2
   logic                l2_req;
   ext_mem_pkg::waddr_t l2_addr;
   ext_mem_pkg::word_t  l2_wdata;
   ext_mem_pkg::wstrb_t l2_wstrb;
   ext_mem_pkg::word_t  l2_rdata;
   logic                l2_ack;

   ext_mem_pkg::word_t  dc_rdata;
   logic                dc_ack;
   logic                dc_rvalid;

   logic ctrl_sel;    // Address in control region
   logic ctrl_req;
   logic dc_req;
   logic ctrl_start;  // First cycle of a control access
   logic ctrl_ack_q;
   logic invalidate;  // One-cycle strobe to all caches

   assign ctrl_sel   = d_addr_i[ext_mem_pkg::ADDR_W];
   assign ctrl_req   = d_req_i && ctrl_sel;
   assign dc_req     = d_req_i && !ctrl_sel;
   assign ctrl_start = ctrl_req && !ctrl_ack_q; // Held req is not taken twice
   assign invalidate = ctrl_ack_q;

   // Control write acks next cycle
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         ctrl_ack_q <= 1'b0;
      end else begin
         ctrl_ack_q <= ctrl_start;
      end
   end

   // d port response from whichever side owns the request
   assign d_ack_o    = dc_ack || ctrl_ack_q;
   assign d_rvalid_o = dc_rvalid;                  // Control reads give nothing
   assign d_rdata_o  = ctrl_ack_q ? '0 : dc_rdata;

   wt_cache #(.LINES_W(ext_mem_pkg::L1_LINES_W)) icache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(i_req_i), .addr_i(i_addr_i), .wdata_i(i_wdata_i), .wstrb_i(i_wstrb_i),
      .rdata_o(i_rdata_o), .ack_o(i_ack_o), .rvalid_o(i_rvalid_o),
      .invalidate_i(invalidate),
      .be_req_o(ic_be_req), .be_addr_o(ic_be_addr), .be_wdata_o(ic_be_wdata),
      .be_wstrb_o(ic_be_wstrb), .be_rdata_i(ic_be_rdata), .be_ack_i(ic_be_ack)
   );

   wt_cache #(.LINES_W(ext_mem_pkg::L1_LINES_W)) dcache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(dc_req), .addr_i(d_addr_i[ext_mem_pkg::ADDR_W-1:0]),
      .wdata_i(d_wdata_i), .wstrb_i(d_wstrb_i),
      .rdata_o(dc_rdata), .ack_o(dc_ack), .rvalid_o(dc_rvalid),
      .invalidate_i(invalidate),
      .be_req_o(dc_be_req), .be_addr_o(dc_be_addr), .be_wdata_o(dc_be_wdata),
      .be_wstrb_o(dc_be_wstrb), .be_rdata_i(dc_be_rdata), .be_ack_i(dc_be_ack)
   );

   // icache on side a, dcache on side b
   be_merge merge_i_d (
      .clk_i(clk_i), .arst_i(arst_i),
      .a_req_i(ic_be_req), .a_addr_i(ic_be_addr), .a_wdata_i(ic_be_wdata),
      .a_wstrb_i(ic_be_wstrb), .a_rdata_o(ic_be_rdata), .a_ack_o(ic_be_ack),
      .b_req_i(dc_be_req), .b_addr_i(dc_be_addr), .b_wdata_i(dc_be_wdata),
      .b_wstrb_i(dc_be_wstrb), .b_rdata_o(dc_be_rdata), .b_ack_o(dc_be_ack),
      .s_req_o(l2_req), .s_addr_o(l2_addr), .s_wdata_o(l2_wdata),
      .s_wstrb_o(l2_wstrb), .s_rdata_i(l2_rdata), .s_ack_i(l2_ack)
   );

   wt_cache #(.LINES_W(ext_mem_pkg::L2_LINES_W)) l2cache (
      .clk_i(clk_i), .arst_i(arst_i),
      .req_i(l2_req), .addr_i(l2_addr), .wdata_i(l2_wdata), .wstrb_i(l2_wstrb),
      .rdata_o(l2_rdata), .ack_o(l2_ack),
      .rvalid_o(),  // Merge only needs ack
      .invalidate_i(invalidate),
      .be_req_o(mem_req_o), .be_addr_o(mem_addr_o), .be_wdata_o(mem_wdata_o),
      .be_wstrb_o(mem_wstrb_o), .be_rdata_i(mem_rdata_i), .be_ack_i(mem_ack_i)
   );

   // Control region takes writes only
   a_ctrl_write: assert property (@(posedge clk_i) disable iff (arst_i)
      ctrl_start |-> (d_wstrb_i != '0))
      else $error("ext_mem: read of the control region");

endmodule

`default_nettype wire

// ==== hw/be_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module be_merge (
   input  wire logic                clk_i,
   input  wire logic                arst_i,
   // Master a
   input  wire logic                a_req_i,
   input  wire ext_mem_pkg::waddr_t a_addr_i,
   input  wire ext_mem_pkg::word_t  a_wdata_i,
   input  wire ext_mem_pkg::wstrb_t a_wstrb_i,
   output ext_mem_pkg::word_t       a_rdata_o,
   output logic                     a_ack_o,
   // Master b
   input  wire logic                b_req_i,
   input  wire ext_mem_pkg::waddr_t b_addr_i,
   input  wire ext_mem_pkg::word_t  b_wdata_i,
   input  wire ext_mem_pkg::wstrb_t b_wstrb_i,
   output ext_mem_pkg::word_t       b_rdata_o,
   output logic                     b_ack_o,
   // Slave
   output logic                     s_req_o,
   output ext_mem_pkg::waddr_t      s_addr_o,
   output ext_mem_pkg::word_t       s_wdata_o,
   output ext_mem_pkg::wstrb_t      s_wstrb_o,
   input  wire ext_mem_pkg::word_t  s_rdata_i,
   input  wire logic                s_ack_i
);

   logic gnt_vld_q;  // A transfer is in progress
   logic gnt_b_q;    // Owner of that transfer
   logic prio_b_q;   // b wins the next tie
   logic sel_b;

   // Locked owner first, else same-cycle arbitration
   always_comb begin
      if (gnt_vld_q) begin
         sel_b = gnt_b_q;
      end else if (a_req_i && b_req_i) begin
         sel_b = prio_b_q;
      end else begin
         sel_b = b_req_i;
      end
   end

   assign s_req_o   = sel_b ? b_req_i   : a_req_i;
   assign s_addr_o  = sel_b ? b_addr_i  : a_addr_i;
   assign s_wdata_o = sel_b ? b_wdata_i : a_wdata_i;
   assign s_wstrb_o = sel_b ? b_wstrb_i : a_wstrb_i;

   // Data is shared, ack only to the owner
   assign a_rdata_o = s_rdata_i;
   assign b_rdata_o = s_rdata_i;
   assign a_ack_o   = s_ack_i && !sel_b;
   assign b_ack_o   = s_ack_i && sel_b;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         gnt_vld_q <= 1'b0;
         gnt_b_q   <= 1'b0;
         prio_b_q  <= 1'b0;
      end else if (s_ack_i) begin
         gnt_vld_q <= 1'b0;
         prio_b_q  <= !sel_b; // Other side goes first next time
      end else if (s_req_o && !gnt_vld_q) begin
         gnt_vld_q <= 1'b1;
         gnt_b_q   <= sel_b;
      end
   end

   a_one_ack: assert property (@(posedge clk_i) disable iff (arst_i)
      !(a_ack_o && b_ack_o))
      else $error("be_merge: ack routed to both masters");

endmodule

`default_nettype wire

// ==== hw/wt_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module wt_cache #(
   parameter int LINES_W = ext_mem_pkg::L1_LINES_W
) (
   input  wire logic                clk_i,
   input  wire logic                arst_i,
   // Front-end
   input  wire logic                req_i,
   input  wire ext_mem_pkg::waddr_t addr_i,
   input  wire ext_mem_pkg::word_t  wdata_i,
   input  wire ext_mem_pkg::wstrb_t wstrb_i,
   output ext_mem_pkg::word_t       rdata_o,
   output logic                     ack_o,
   output logic                     rvalid_o,
   input  wire logic                invalidate_i,
   // Back-end
   output logic                     be_req_o,
   output ext_mem_pkg::waddr_t      be_addr_o,
   output ext_mem_pkg::word_t       be_wdata_o,
   output ext_mem_pkg::wstrb_t      be_wstrb_o,
   input  wire ext_mem_pkg::word_t  be_rdata_i,
   input  wire logic                be_ack_i
);

   localparam int LINES = 1 << LINES_W;
   localparam int OFF_W = ext_mem_pkg::WORD_OFF_W;
   localparam int TAG_W = ext_mem_pkg::ADDR_W - LINES_W - OFF_W;

   ext_mem_pkg::cache_state_t state_q;

   // Request latched at accept, held until ack
   ext_mem_pkg::waddr_t addr_q;
   ext_mem_pkg::word_t  wdata_q;
   ext_mem_pkg::wstrb_t wstrb_q;
   ext_mem_pkg::word_t  rdata_q;

   logic [OFF_W-1:0]   cnt_q;      // Fill word counter
   logic [LINES-1:0]   valid_q;
   logic               inv_pend_q; // Invalidate waiting for idle

   logic [TAG_W-1:0]    tag_arr  [LINES];
   ext_mem_pkg::word_t  data_arr [LINES << OFF_W];

   logic [LINES_W-1:0] idx;
   logic [TAG_W-1:0]   tag;
   logic [OFF_W-1:0]   word;
   logic               wr;
   logic               hit;
   logic               accept;
   logic               inv_apply;
   logic               fill_last;

   // Address split of the latched request
   assign idx  = addr_q[OFF_W +: LINES_W];
   assign tag  = addr_q[ext_mem_pkg::ADDR_W-1 -: TAG_W];
   assign word = addr_q[OFF_W-1:0];
   assign wr   = wstrb_q != '0;
   assign hit  = valid_q[idx] && (tag_arr[idx] == tag);

   // Pending invalidate waits for an idle cycle without req
   assign inv_apply = (state_q == ext_mem_pkg::CS_IDLE) && inv_pend_q && !req_i;
   assign accept    = (state_q == ext_mem_pkg::CS_IDLE) && req_i;
   assign fill_last = be_ack_i && (cnt_q == {OFF_W{1'b1}});

   // Front-end response
   assign ack_o    = state_q == ext_mem_pkg::CS_ACK;
   assign rvalid_o = ack_o && !wr;  // Reads only
   assign rdata_o  = rdata_q;

   // Back-end request straight from state and latched fields
   assign be_req_o   = (state_q == ext_mem_pkg::CS_FILL) || (state_q == ext_mem_pkg::CS_WRITE);
   assign be_wdata_o = wdata_q;
   assign be_wstrb_o = (state_q == ext_mem_pkg::CS_WRITE) ? wstrb_q : '0; // Fill is a read
   assign be_addr_o  = (state_q == ext_mem_pkg::CS_FILL) ?
                       {addr_q[ext_mem_pkg::ADDR_W-1:OFF_W], cnt_q} : addr_q;

   // Control FSM
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= ext_mem_pkg::CS_IDLE;
         cnt_q   <= '0;
         valid_q <= '0;
      end else begin
         case (state_q)
            ext_mem_pkg::CS_IDLE: begin
               if (inv_apply) begin
                  valid_q <= '0; // Whole cache at once
               end else if (accept) begin
                  state_q <= ext_mem_pkg::CS_LOOKUP;
               end
            end
            ext_mem_pkg::CS_LOOKUP: begin
               cnt_q <= '0;
               if (wr) begin
                  state_q <= ext_mem_pkg::CS_WRITE; // Write through, hit or not
               end else if (hit) begin
                  state_q <= ext_mem_pkg::CS_ACK;
               end else begin
                  state_q <= ext_mem_pkg::CS_FILL;
               end
            end
            ext_mem_pkg::CS_FILL: begin
               if (be_ack_i) begin
                  cnt_q <= cnt_q + 1'b1;
               end
               if (fill_last) begin
                  valid_q[idx] <= 1'b1; // Line complete
                  state_q      <= ext_mem_pkg::CS_ACK;
               end
            end
            ext_mem_pkg::CS_WRITE: begin
               if (be_ack_i) begin
                  state_q <= ext_mem_pkg::CS_ACK;
               end
            end
            default: begin
               state_q <= ext_mem_pkg::CS_IDLE; // Ack lasts one cycle
            end
         endcase
      end
   end

   // Invalidate strobe is held here until idle
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         inv_pend_q <= 1'b0;
      end else if (invalidate_i) begin
         inv_pend_q <= 1'b1;
      end else if (inv_apply) begin
         inv_pend_q <= 1'b0;
      end
   end

   // Request fields
   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
   end

   // Read data from a hit or from the matching fill beat
   always_ff @(posedge clk_i) begin
      if (state_q == ext_mem_pkg::CS_LOOKUP && hit) begin
         rdata_q <= data_arr[{idx, word}];
      end else if (state_q == ext_mem_pkg::CS_FILL && be_ack_i && cnt_q == word) begin
         rdata_q <= be_rdata_i;
      end
   end

   // Line storage
   always_ff @(posedge clk_i) begin
      if (state_q == ext_mem_pkg::CS_FILL && be_ack_i) begin
         data_arr[{idx, cnt_q}] <= be_rdata_i; // Install each beat
      end else if (state_q == ext_mem_pkg::CS_LOOKUP && hit && wr) begin
         for (int b = 0; b < ext_mem_pkg::STRB_W; b++) begin
            if (wstrb_q[b]) begin
               data_arr[{idx, word}][8*b +: 8] <= wdata_q[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ext_mem_pkg::CS_FILL && fill_last) begin
         tag_arr[idx] <= tag;
      end
   end

   a_be_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      be_req_o && !be_ack_i |=> be_req_o && $stable(be_addr_o) &&
                                $stable(be_wdata_o) && $stable(be_wstrb_o))
      else $error("wt_cache: back-end request changed before ack");

   a_ack_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      ack_o |=> !ack_o)
      else $error("wt_cache: ack longer than one cycle");

   // Valid bits only drop while idle
   a_inv_idle: assert property (@(posedge clk_i) disable iff (arst_i)
      (state_q != ext_mem_pkg::CS_IDLE) |=> ((valid_q & $past(valid_q)) == $past(valid_q)))
      else $error("wt_cache: invalidate applied outside idle");

endmodule

`default_nettype wire

// ==== hw/ext_mem_pkg.sv ====
`default_nettype none

package ext_mem_pkg;

   // Bus widths
   localparam int DATA_W = 32;       // Data word
   localparam int ADDR_W = 14;       // Word address on memory side ports
   localparam int STRB_W = DATA_W / 8;

   // Cache geometry
   localparam int WORD_OFF_W = 2;    // Four words per line
   localparam int L1_LINES_W = 4;    // 16 lines in each L1
   localparam int L2_LINES_W = 6;    // 64 lines in L2

   // Data word as seen on every port
   typedef logic [DATA_W-1:0] word_t;

   // Word address, no byte offset bits
   typedef logic [ADDR_W-1:0] waddr_t;

   // Byte strobe, all zero marks a read
   typedef logic [STRB_W-1:0] wstrb_t;

   // Cache controller states
   typedef enum logic [2:0] {
      CS_IDLE,    // Waiting for req, applies pending invalidate
      CS_LOOKUP,  // Tag compare on latched address
      CS_FILL,    // Four back-end reads of the line
      CS_WRITE,   // Single back-end write
      CS_ACK      // Front-end ack pulse
   } cache_state_t;

endpackage

`default_nettype wire
